/* build.f */
switch_dims_pkg.sv
switch_cell_pkg.sv
voq_if.sv
voq.sv
ingress_rotator.sv
transfer_scheduler.sv
switch_fabric.sv
switch_fabric_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = switch_fabric_tb
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* switch_fabric_tb.sv */
`timescale 1ns/100ps

module switch_fabric_tb import switch_dims_pkg::*; ();

    localparam int NUM_ROWS      = 10;
    localparam int SEND_TIMEOUT  = 400;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int IDLE_CYCLES   = 24;

    typedef enum logic [2:0] {
        ONE_TO_ONE,
        ALL_TO_ONE,
        PERMUTE,
        RANDOM,
        FLOOD
    } traffic_e;

    // count is the number of cells per sending port.
    // drain turns on the output reads while the row is sending.
    typedef struct {
        traffic_e kind;
        port_id_t src;
        port_id_t dst;
        int       count;
        logic     drain;
    } row_t;

    logic                            clk = 1'b0;
    logic                            rst_n;
    logic [NUM_PORTS-1:0]            in_valid;
    logic [NUM_PORTS*SEL_WIDTH-1:0]  in_dst;
    logic [NUM_PORTS*DATA_WIDTH-1:0] in_data;
    logic [NUM_PORTS-1:0]            in_ready;
    logic [NUM_PORTS-1:0]            out_rd_en;
    logic [NUM_PORTS*SEL_WIDTH-1:0]  out_rd_sel;
    logic [NUM_PORTS*DATA_WIDTH-1:0] out_data;
    logic [NUM_PORTS*NUM_PORTS-1:0]  out_empty;

    // the sent payloads of each (source, destination) pair sit at index src*NUM_PORTS+dst.
    payload_t             sb [NUM_PORTS*NUM_PORTS][$];
    logic [NUM_PORTS-1:0] rd_pend;
    port_id_t             rd_src [NUM_PORTS];
    port_id_t             rd_rr [NUM_PORTS];
    logic                 reads_on;

    logic [NUM_PORTS-1:0] cur_valid;
    port_id_t             cur_dst [NUM_PORTS];
    payload_t             cur_data [NUM_PORTS];
    int                   left_cnt [NUM_PORTS];

    logic [31:0] rng_state;
    int          err_cnt;
    int          timeout_cnt;
    int          accepted_cnt;
    int          received_cnt;
    row_t        rows [NUM_ROWS];

    switch_fabric #(
        .QUEUE_DEPTH (4)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_dst     (in_dst),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_rd_en  (out_rd_en),
        .out_rd_sel (out_rd_sel),
        .out_data   (out_data),
        .out_empty  (out_empty)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // out_data holds the cells popped at the last rising edge.
    task automatic check_reads();
        payload_t got;
        int       idx;
        int       hit;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (rd_pend[o]) begin
                got = out_data[o*DATA_WIDTH +: DATA_WIDTH];
                idx = int'(rd_src[o]) * NUM_PORTS + o;
                hit = -1;
                received_cnt++;
                for (int i = 0; i < sb[idx].size(); i++) begin
                    if (hit < 0 && sb[idx][i] == got) begin
                        hit = i;
                    end
                end
                if (hit >= 0) begin
                    sb[idx].delete(hit);
                end else if (sb[idx].size() == 0) begin
                    err_cnt++;
                    $display("FAILED out_data[%0d] source %0d: got %h, expected no cell",
                             o, rd_src[o], got);
                end else begin
                    err_cnt++;
                    $display("FAILED out_data[%0d] source %0d: got %h, expected %h",
                             o, rd_src[o], got, sb[idx][0]);
                end
            end
        end
    endtask

    task automatic issue_reads();
        port_id_t s;
        logic     found;
        for (int o = 0; o < NUM_PORTS; o++) begin
            found        = 1'b0;
            rd_pend[o]   = 1'b0;
            out_rd_en[o] = 1'b0;
            if (reads_on) begin
                for (int k = 0; k < NUM_PORTS; k++) begin
                    s = rd_rr[o] + port_id_t'(k);
                    if (!found && !out_empty[o*NUM_PORTS + int'(s)]) begin
                        found        = 1'b1;
                        out_rd_en[o] = 1'b1;
                        out_rd_sel[o*SEL_WIDTH +: SEL_WIDTH] = s;
                        rd_pend[o]   = 1'b1;
                        rd_src[o]    = s;
                        rd_rr[o]     = s + port_id_t'(1);
                    end
                end
            end
        end
    endtask

    task automatic clock_step();
        @(negedge clk);
        check_reads();
        issue_reads();
    endtask

    task automatic drive_inputs();
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_valid[p] = cur_valid[p];
            in_dst[p*SEL_WIDTH +: SEL_WIDTH]   = cur_dst[p];
            in_data[p*DATA_WIDTH +: DATA_WIDTH] = cur_data[p];
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        if (out_empty !== '1) begin
            err_cnt++;
            $display("FAILED out_empty after reset: got %h, expected %h", out_empty, {16{1'b1}});
        end
        if (in_ready !== '1) begin
            err_cnt++;
            $display("FAILED in_ready after reset: got %h, expected %h", in_ready, 4'hf);
        end
        out_rd_en[2] = 1'b1;
        out_rd_sel[2*SEL_WIDTH +: SEL_WIDTH] = port_id_t'(1);
        @(negedge clk);
        out_rd_en = '0;
        @(negedge clk);
        if (out_empty !== '1) begin
            err_cnt++;
            $display("FAILED out_empty after empty read: got %h, expected %h",
                     out_empty, {16{1'b1}});
        end
    endtask

    task automatic drain_outputs(input int row_idx);
        int   cycles;
        logic done;
        reads_on = 1'b1;
        cycles   = 0;
        done     = 1'b0;
        while (!done) begin
            clock_step();
            drive_inputs();
            cycles++;
            if (received_cnt == accepted_cnt && rd_pend == '0 && &out_empty) begin
                done = 1'b1;
            end else if (cycles >= DRAIN_TIMEOUT) begin
                timeout_cnt++;
                $display("timeout: outputs of row %0d did not drain, %0d cells missing",
                         row_idx, accepted_cnt - received_cnt);
                done = 1'b1;
            end
        end
        // late or duplicate cells would show up here as unmatched reads.
        repeat (IDLE_CYCLES) begin
            clock_step();
            drive_inputs();
        end
        if (received_cnt != accepted_cnt) begin
            err_cnt++;
            $display("FAILED cells received after row %0d: got %h, expected %h",
                     row_idx, received_cnt, accepted_cnt);
        end
        if (out_empty !== '1) begin
            err_cnt++;
            $display("FAILED out_empty after row %0d: got %h, expected %h",
                     row_idx, out_empty, {16{1'b1}});
        end
    endtask

    task automatic run_row(input int row_idx);
        row_t r;
        int   cycles;
        logic busy;
        logic saw_block;
        r         = rows[row_idx];
        reads_on  = r.drain;
        cycles    = 0;
        saw_block = 1'b0;
        cur_valid = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (r.kind == ONE_TO_ONE || r.kind == FLOOD) begin
                left_cnt[p] = (port_id_t'(p) == r.src) ? r.count : 0;
            end else begin
                left_cnt[p] = r.count;
            end
        end
        busy = 1'b1;
        while (busy) begin
            clock_step();
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!cur_valid[p] && left_cnt[p] > 0) begin
                    rng_state   = lcg_step(rng_state);
                    cur_data[p] = rng_state[31:16];
                    if (r.kind == RANDOM) begin
                        cur_dst[p] = rng_state[8 +: SEL_WIDTH];
                    end else if (r.kind == PERMUTE) begin
                        cur_dst[p] = port_id_t'(p) + r.dst;
                    end else begin
                        cur_dst[p] = r.dst;
                    end
                    cur_valid[p] = 1'b1;
                    left_cnt[p]--;
                end
            end
            drive_inputs();
            #1;
            // in_ready is settled here and holds until the rising edge.
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cur_valid[p] && in_ready[p]) begin
                    sb[p*NUM_PORTS + int'(cur_dst[p])].push_back(cur_data[p]);
                    accepted_cnt++;
                    cur_valid[p] = 1'b0;
                end else if (cur_valid[p] && r.kind == FLOOD) begin
                    saw_block = 1'b1;
                end
            end
            cycles++;
            busy = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cur_valid[p] || left_cnt[p] > 0) begin
                    busy = 1'b1;
                end
            end
            if (r.kind == FLOOD && saw_block) begin
                busy = 1'b0;
            end else if (busy && cycles >= SEND_TIMEOUT) begin
                timeout_cnt++;
                $display("timeout: row %0d could not send all of its cells", row_idx);
                busy = 1'b0;
            end
        end
        if (r.kind == FLOOD && !saw_block) begin
            err_cnt++;
            $display("in_ready of port %0d never went low without output reads", r.src);
        end
        cur_valid = '0;
        drain_outputs(row_idx);
        $display("row %0d done, %0d cells accepted in total", row_idx, accepted_cnt);
    endtask

    initial begin
        rst_n        = 1'b0;
        in_valid     = '0;
        in_dst       = '0;
        in_data      = '0;
        out_rd_en    = '0;
        out_rd_sel   = '0;
        rng_state    = 32'h2d59;
        err_cnt      = 0;
        timeout_cnt  = 0;
        accepted_cnt = 0;
        received_cnt = 0;
        rd_pend      = '0;
        reads_on     = 1'b0;
        cur_valid    = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rd_src[p]   = '0;
            rd_rr[p]    = '0;
            cur_dst[p]  = '0;
            cur_data[p] = '0;
            left_cnt[p] = 0;
        end

        rows[0] = '{ONE_TO_ONE, 2'd1, 2'd2, 1, 1'b1};
        rows[1] = '{ONE_TO_ONE, 2'd3, 2'd0, 1, 1'b0};
        rows[2] = '{ALL_TO_ONE, 2'd0, 2'd1, 6, 1'b1};
        rows[3] = '{ALL_TO_ONE, 2'd0, 2'd3, 4, 1'b0};
        rows[4] = '{PERMUTE, 2'd0, 2'd1, 12, 1'b1};
        rows[5] = '{PERMUTE, 2'd0, 2'd3, 8, 1'b1};
        rows[6] = '{RANDOM, 2'd0, 2'd0, 16, 1'b1};
        rows[7] = '{RANDOM, 2'd0, 2'd0, 4, 1'b0};
        rows[8] = '{FLOOD, 2'd2, 2'd0, 60, 1'b0};
        rows[9] = '{ONE_TO_ONE, 2'd0, 2'd3, 1, 1'b1};

        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("errors %0d, timeouts %0d, cells accepted %0d, cells received %0d",
                 err_cnt, timeout_cnt, accepted_cnt, received_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* switch_fabric.sv */
`timescale 1ns/100ps

module switch_fabric import switch_dims_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic [NUM_PORTS-1:0]           in_valid,
    input  logic [NUM_PORTS*SEL_WIDTH-1:0] in_dst,
    input  logic [NUM_PORTS*DATA_WIDTH-1:0] in_data,
    output logic [NUM_PORTS-1:0]           in_ready,

    input  logic [NUM_PORTS-1:0]           out_rd_en,
    input  logic [NUM_PORTS*SEL_WIDTH-1:0] out_rd_sel,
    output logic [NUM_PORTS*DATA_WIDTH-1:0] out_data,
    output logic [NUM_PORTS*NUM_PORTS-1:0] out_empty
);

    port_id_t in_dst_arr [NUM_PORTS];
    payload_t in_data_arr [NUM_PORTS];

    voq_if lane_q [NUM_PORTS] ();
    voq_if out_q [NUM_PORTS] ();

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_unpack
        assign in_dst_arr[p]  = in_dst[p*SEL_WIDTH +: SEL_WIDTH];
        assign in_data_arr[p] = in_data[p*DATA_WIDTH +: DATA_WIDTH];
    end

    ingress_rotator u_rotator (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_dst   (in_dst_arr),
        .in_data  (in_data_arr),
        .in_ready (in_ready),
        .lane_q   (lane_q)
    );

    for (genvar l = 0; l < NUM_PORTS; l++) begin : g_lane
        voq #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_lane_voq (
            .clk   (clk),
            .rst_n (rst_n),
            .q     (lane_q[l])
        );
    end

    transfer_scheduler u_sched (
        .clk    (clk),
        .rst_n  (rst_n),
        .lane_q (lane_q),
        .out_q  (out_q)
    );

    // outside logic reads the output queues directly.
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        voq #(
            .QUEUE_DEPTH (QUEUE_DEPTH)
        ) u_out_voq (
            .clk   (clk),
            .rst_n (rst_n),
            .q     (out_q[o])
        );

        assign out_q[o].rd_en  = out_rd_en[o];
        assign out_q[o].rd_sel = out_rd_sel[o*SEL_WIDTH +: SEL_WIDTH];
        assign out_data[o*DATA_WIDTH +: DATA_WIDTH] = out_q[o].rd_cell.data;
        assign out_empty[o*NUM_PORTS +: NUM_PORTS]  = out_q[o].empty;
    end

endmodule

/* transfer_scheduler.sv */
`timescale 1ns/100ps

module transfer_scheduler import switch_dims_pkg::*, switch_cell_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    voq_if.reader lane_q [NUM_PORTS],
    voq_if.writer out_q [NUM_PORTS]
);

    xfer_phase_e          phase;
    port_id_t             out_ptr;
    port_id_t             lane_ptr [NUM_PORTS];
    logic [NUM_PORTS-1:0] match_valid;
    port_id_t             match_lane [NUM_PORTS];

    logic [NUM_PORTS-1:0] lane_empty [NUM_PORTS];
    cell_t                lane_cell [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_blocked;

    logic [NUM_PORTS-1:0] pick_valid;
    port_id_t             pick_lane [NUM_PORTS];
    logic [NUM_PORTS-1:0] lane_taken;
    port_id_t             lane_sel [NUM_PORTS];

    // an output with any full sub-queue is skipped, since the source
    // of the next cell is only known after the lane read.
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out_state
        assign out_blocked[o] = |out_q[o].full;
    end

    always_comb begin
        port_id_t o;
        port_id_t l;

        pick_valid = '0;
        lane_taken = '0;
        o          = '0;
        l          = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            pick_lane[i] = '0;
            lane_sel[i]  = '0;
        end
        for (int k = 0; k < NUM_PORTS; k++) begin
            o = out_ptr + port_id_t'(k);
            if (!out_blocked[o]) begin
                for (int j = 0; j < NUM_PORTS; j++) begin
                    l = lane_ptr[o] + port_id_t'(j + 1);
                    if (!pick_valid[o] && !lane_taken[l] && !lane_empty[l][o]) begin
                        pick_valid[o] = 1'b1;
                        pick_lane[o]  = l;
                        lane_taken[l] = 1'b1;
                        lane_sel[l]   = o;
                    end
                end
            end
        end
    end

    for (genvar l = 0; l < NUM_PORTS; l++) begin : g_lane
        assign lane_empty[l]   = lane_q[l].empty;
        assign lane_cell[l]    = lane_q[l].rd_cell;
        assign lane_q[l].rd_en  = (phase == XFER_PICK) && lane_taken[l];
        assign lane_q[l].rd_sel = lane_sel[l];
    end

    // the lane read data arrives in the move cycle and goes out keyed by source.
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        cell_t move_cell;

        assign move_cell       = lane_cell[match_lane[o]];
        assign out_q[o].wr_en   = (phase == XFER_MOVE) && match_valid[o];
        assign out_q[o].wr_sel  = move_cell.src;
        assign out_q[o].wr_cell = move_cell;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= XFER_PICK;
            out_ptr     <= '0;
            match_valid <= '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                lane_ptr[i]   <= port_id_t'(NUM_PORTS - 1);
                match_lane[i] <= '0;
            end
        end else if (phase == XFER_PICK) begin
            phase       <= XFER_MOVE;
            match_valid <= pick_valid;
            match_lane  <= pick_lane;
        end else begin
            phase   <= XFER_PICK;
            out_ptr <= out_ptr + 1'b1;
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (match_valid[i]) begin
                    lane_ptr[i] <= match_lane[i];
                end
            end
        end
    end

endmodule

/* ingress_rotator.sv */
`timescale 1ns/100ps

module ingress_rotator import switch_dims_pkg::*, switch_cell_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NUM_PORTS-1:0] in_valid,
    input  port_id_t             in_dst [NUM_PORTS],
    input  payload_t             in_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0] in_ready,
    voq_if.writer                lane_q [NUM_PORTS]
);

    port_id_t             offset;
    logic [NUM_PORTS-1:0] lane_full [NUM_PORTS];

    // the rotation offset walks through all lanes, one step per cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset <= '0;
        end else begin
            offset <= offset + 1'b1;
        end
    end

    // each lane takes the cell of the port that maps onto it this cycle
    // and files it under its destination.
    for (genvar l = 0; l < NUM_PORTS; l++) begin : g_lane
        port_id_t src;

        assign src          = port_id_t'(l) - offset;
        assign lane_full[l] = lane_q[l].full;

        assign lane_q[l].wr_en   = in_valid[src] && in_ready[src];
        assign lane_q[l].wr_sel  = in_dst[src];
        assign lane_q[l].wr_cell = cell_t'{
            src:  src,
            dst:  in_dst[src],
            data: in_data[src]
        };
    end

    // a port is ready when its current lane has room for its destination.
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        port_id_t lane;

        assign lane        = port_id_t'(p) + offset;
        assign in_ready[p] = !lane_full[lane][in_dst[p]];
    end

endmodule

/* voq.sv */
`timescale 1ns/100ps

module voq import switch_dims_pkg::*, switch_cell_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    voq_if.queue q
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic  do_wr;
    logic  do_rd;
    cell_t head [NUM_PORTS];

    assign do_wr = q.wr_en && !q.full[q.wr_sel];
    assign do_rd = q.rd_en && !q.empty[q.rd_sel];

    for (genvar s = 0; s < NUM_PORTS; s++) begin : g_sub
        cell_t            mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W:0]   count;
        logic             wr_hit;
        logic             rd_hit;

        assign wr_hit = do_wr && (q.wr_sel == port_id_t'(s));
        assign rd_hit = do_rd && (q.rd_sel == port_id_t'(s));

        always_ff @(posedge clk) begin
            if (wr_hit) begin
                mem[wr_ptr] <= q.wr_cell;
            end
        end

        // pointers wrap on their own since the depth is a power of two.
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_hit) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (rd_hit) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                if (wr_hit && !rd_hit) begin
                    count <= count + 1'b1;
                end else if (rd_hit && !wr_hit) begin
                    count <= count - 1'b1;
                end
            end
        end

        assign head[s]    = mem[rd_ptr];
        assign q.full[s]  = (count == (PTR_W+1)'(QUEUE_DEPTH));
        assign q.empty[s] = (count == '0);
    end

    // popped cell is held until the next successful read.
    always_ff @(posedge clk) begin
        if (do_rd) begin
            q.rd_cell <= head[q.rd_sel];
        end
    end

endmodule

/* voq_if.sv */
`timescale 1ns/100ps

interface voq_if import switch_dims_pkg::*, switch_cell_pkg::*; ();

    logic                 wr_en;
    port_id_t             wr_sel;
    cell_t                wr_cell;
    logic [NUM_PORTS-1:0] full;

    logic                 rd_en;
    port_id_t             rd_sel;
    cell_t                rd_cell;
    logic [NUM_PORTS-1:0] empty;

    modport queue (
        input  wr_en,
        input  wr_sel,
        input  wr_cell,
        output full,
        input  rd_en,
        input  rd_sel,
        output rd_cell,
        output empty
    );

    modport writer (
        output wr_en,
        output wr_sel,
        output wr_cell,
        input  full
    );

    modport reader (
        output rd_en,
        output rd_sel,
        input  rd_cell,
        input  empty
    );

endinterface

/* switch_cell_pkg.sv */
package switch_cell_pkg;

    import switch_dims_pkg::*;

    // a cell carries its source so that the output stage can sort by origin.
    typedef struct packed {
        port_id_t src;
        port_id_t dst;
        payload_t data;
    } cell_t;

    // the transfer scheduler alternates between choosing a matching
    // and moving the cells that were read during the choice.
    typedef enum logic {
        XFER_PICK,
        XFER_MOVE
    } xfer_phase_e;

endpackage

/* switch_dims_pkg.sv */
package switch_dims_pkg;

    // number of input ports, middle lanes and output ports.
    parameter int NUM_PORTS = 4;

    // width of the cell payload.
    parameter int DATA_WIDTH = 16;

    // bits needed to address one port.
    parameter int SEL_WIDTH = $clog2(NUM_PORTS);

    typedef logic [SEL_WIDTH-1:0] port_id_t;

    typedef logic [DATA_WIDTH-1:0] payload_t;

endpackage
